// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mesh_pod_array
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+rtl
rtl/mesh_pkg.sv
rtl/mesh_node.sv
rtl/mesh_tile_mem.sv
rtl/mesh_pod.sv
rtl/mesh_pod_array.sv
verif/tb_mesh_pod_array.sv

// ==== rtl/mesh_macros.svh ====
// ##########################################################################
// geometry, field widths and reset depth of the mesh array
// two pods of 2x2 tiles, one north IO row of four routers
// ##########################################################################
`ifndef MESH_MACROS_SVH
`define MESH_MACROS_SVH

`define MESH_PODS_X      2
`define MESH_TILES_X     2
`define MESH_TILES_Y     2
`define MESH_COLS        (`MESH_PODS_X * `MESH_TILES_X)

// coordinate field widths with y 0 as the IO row
`define MESH_X_W         3
`define MESH_Y_W         2

`define MESH_ADDR_W      4
`define MESH_DATA_W      32
`define MESH_RESET_DEPTH 3

`endif

// ==== rtl/mesh_node.sv ====
// ##########################################################################
// five-port mesh router
// one-entry buffer per input port, XY dimension-ordered routing
// round-robin arbitration per output port
// ##########################################################################
`include "mesh_macros.svh"

module mesh_node
  import mesh_pkg::*;
#(
  parameter int x_cord_p = 0,
  parameter int y_cord_p = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  mesh_link_s [dir_s:dir_p]    link_i,
  output logic       [dir_s:dir_p]    link_ready_o,
  output mesh_link_s [dir_s:dir_p]    link_o,
  input  logic       [dir_s:dir_p]    link_ready_i
);

  localparam int dirs_lp = int'(dir_s) + 1;
  localparam logic [`MESH_X_W-1:0] x_lp = (`MESH_X_W)'(x_cord_p);
  localparam logic [`MESH_Y_W-1:0] y_lp = (`MESH_Y_W)'(y_cord_p);

  // input buffers
  logic      [dir_s:dir_p] buf_v_r;
  mesh_pkt_s [dir_s:dir_p] buf_pkt_r;

  // goes high one cycle after reset is released
  logic live_r;

  mesh_dir_e route [dirs_lp];
  // req[out][in]
  logic [dir_s:dir_p][dir_s:dir_p] req;
  logic [dir_s:dir_p]              gnt_v;
  logic [dir_s:dir_p][2:0]         gnt_idx;
  logic [dir_s:dir_p][2:0]         rr_r;
  logic [dir_s:dir_p]              pop;

  // x first, then y, own coordinate goes to the local port
  function automatic mesh_dir_e route_f(mesh_pkt_s pkt);
    mesh_dir_e dir;
    if (pkt.dst_x > x_lp) begin
      dir = dir_e;
    end else if (pkt.dst_x < x_lp) begin
      dir = dir_w;
    end else if (pkt.dst_y > y_lp) begin
      dir = dir_s;
    end else if (pkt.dst_y < y_lp) begin
      dir = dir_n;
    end else begin
      dir = dir_p;
    end
    return dir;
  endfunction

  always_comb begin
    for (int i = 0; i < dirs_lp; i++) begin
      route[i] = route_f(buf_pkt_r[i]);
    end
    for (int o = 0; o < dirs_lp; o++) begin
      for (int i = 0; i < dirs_lp; i++) begin
        req[o][i] = buf_v_r[i] && (route[i] == mesh_dir_e'(o));
      end
    end
  end

  // search starts at the pointer and wraps around
  always_comb begin
    int idx;
    gnt_v   = '0;
    gnt_idx = '0;
    pop     = '0;
    for (int o = 0; o < dirs_lp; o++) begin
      for (int k = 0; k < dirs_lp; k++) begin
        idx = (int'(rr_r[o]) + k) % dirs_lp;
        if (!gnt_v[o] && req[o][idx]) begin
          gnt_v[o]   = 1'b1;
          gnt_idx[o] = 3'(idx);
        end
      end
      if (gnt_v[o] && link_ready_i[o]) begin
        pop[gnt_idx[o]] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < dirs_lp; o++) begin
      link_o[o].v   = gnt_v[o];
      link_o[o].pkt = buf_pkt_r[gnt_idx[o]];
    end
  end

  // a full buffer takes nothing, so accept and pop never overlap
  assign link_ready_o = {dirs_lp{live_r}} & ~buf_v_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      live_r  <= 1'b0;
      buf_v_r <= '0;
      rr_r    <= '0;
    end else begin
      live_r <= 1'b1;
      for (int i = 0; i < dirs_lp; i++) begin
        if (link_i[i].v && link_ready_o[i]) begin
          buf_v_r[i] <= 1'b1;
        end else if (pop[i]) begin
          buf_v_r[i] <= 1'b0;
        end
      end
      for (int o = 0; o < dirs_lp; o++) begin
        if (gnt_v[o] && link_ready_i[o]) begin
          rr_r[o] <= (gnt_idx[o] == 3'(dirs_lp - 1)) ? 3'd0 : gnt_idx[o] + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < dirs_lp; i++) begin
      if (link_i[i].v && link_ready_o[i]) begin
        buf_pkt_r[i] <= link_i[i].pkt;
      end
    end
  end

endmodule

// ==== rtl/mesh_pkg.sv ====
// ##########################################################################
// shared types of the mesh array
//   mesh_op_e   packet opcode
//   mesh_dir_e  router port index
//   mesh_pkt_s  routed packet
//   mesh_link_s forward half of a link, ready runs back separately
// ##########################################################################
`include "mesh_macros.svh"

package mesh_pkg;

  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_resp  = 2'd2
  } mesh_op_e;

  // west/east and north/south pairs sit next to each other
  typedef enum logic [2:0] {
    dir_p = 3'd0,
    dir_w = 3'd1,
    dir_e = 3'd2,
    dir_n = 3'd3,
    dir_s = 3'd4
  } mesh_dir_e;

  typedef struct packed {
    mesh_op_e                 op;
    logic [`MESH_X_W-1:0]     src_x;
    logic [`MESH_Y_W-1:0]     src_y;
    logic [`MESH_X_W-1:0]     dst_x;
    logic [`MESH_Y_W-1:0]     dst_y;
    logic [`MESH_ADDR_W-1:0]  addr;
    logic [`MESH_DATA_W-1:0]  data;
  } mesh_pkt_s;

  typedef struct packed {
    logic      v;
    mesh_pkt_s pkt;
  } mesh_link_s;

endpackage

// ==== rtl/mesh_pod.sv ====
// ##########################################################################
// pod of 2x2 tiles, each a mesh router with a memory endpoint
// pod edge links come out as west/east and north/south ports
// ##########################################################################
`include "mesh_macros.svh"

module mesh_pod
  import mesh_pkg::*;
#(
  parameter int pod_x_p = 0
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  mesh_link_s [dir_e:dir_w][`MESH_TILES_Y-1:0]  hor_i,
  output logic       [dir_e:dir_w][`MESH_TILES_Y-1:0]  hor_ready_o,
  output mesh_link_s [dir_e:dir_w][`MESH_TILES_Y-1:0]  hor_o,
  input  logic       [dir_e:dir_w][`MESH_TILES_Y-1:0]  hor_ready_i,
  input  mesh_link_s [dir_s:dir_n][`MESH_TILES_X-1:0]  ver_i,
  output logic       [dir_s:dir_n][`MESH_TILES_X-1:0]  ver_ready_o,
  output mesh_link_s [dir_s:dir_n][`MESH_TILES_X-1:0]  ver_o,
  input  logic       [dir_s:dir_n][`MESH_TILES_X-1:0]  ver_ready_i
);

  localparam int tx_lp = `MESH_TILES_X;
  localparam int ty_lp = `MESH_TILES_Y;

  // per router, li feeds the router and lo comes out of it
  mesh_link_s [ty_lp-1:0][tx_lp-1:0][dir_s:dir_p] node_li;
  mesh_link_s [ty_lp-1:0][tx_lp-1:0][dir_s:dir_p] node_lo;
  logic       [ty_lp-1:0][tx_lp-1:0][dir_s:dir_p] node_rdy_li;
  logic       [ty_lp-1:0][tx_lp-1:0][dir_s:dir_p] node_rdy_lo;

  for (genvar r = 0; r < ty_lp; r++) begin : g_row
    for (genvar c = 0; c < tx_lp; c++) begin : g_col

      mesh_node #(
        .x_cord_p(pod_x_p * tx_lp + c),
        .y_cord_p(r + 1)
      ) node (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .link_i      (node_li[r][c]),
        .link_ready_o(node_rdy_lo[r][c]),
        .link_o      (node_lo[r][c]),
        .link_ready_i(node_rdy_li[r][c])
      );

      mesh_tile_mem mem (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (node_lo[r][c][dir_p]),
        .req_ready_o (node_rdy_li[r][c][dir_p]),
        .resp_o      (node_li[r][c][dir_p]),
        .resp_ready_i(node_rdy_lo[r][c][dir_p])
      );

      // west side
      if (c == 0) begin : g_w_edge
        assign node_li[r][c][dir_w]     = hor_i[dir_w][r];
        assign node_rdy_li[r][c][dir_w] = hor_ready_i[dir_w][r];
        assign hor_o[dir_w][r]          = node_lo[r][c][dir_w];
        assign hor_ready_o[dir_w][r]    = node_rdy_lo[r][c][dir_w];
      end else begin : g_w_link
        assign node_li[r][c][dir_w]     = node_lo[r][c-1][dir_e];
        assign node_rdy_li[r][c][dir_w] = node_rdy_lo[r][c-1][dir_e];
      end

      // east side
      if (c == tx_lp - 1) begin : g_e_edge
        assign node_li[r][c][dir_e]     = hor_i[dir_e][r];
        assign node_rdy_li[r][c][dir_e] = hor_ready_i[dir_e][r];
        assign hor_o[dir_e][r]          = node_lo[r][c][dir_e];
        assign hor_ready_o[dir_e][r]    = node_rdy_lo[r][c][dir_e];
      end else begin : g_e_link
        assign node_li[r][c][dir_e]     = node_lo[r][c+1][dir_w];
        assign node_rdy_li[r][c][dir_e] = node_rdy_lo[r][c+1][dir_w];
      end

      // north side
      if (r == 0) begin : g_n_edge
        assign node_li[r][c][dir_n]     = ver_i[dir_n][c];
        assign node_rdy_li[r][c][dir_n] = ver_ready_i[dir_n][c];
        assign ver_o[dir_n][c]          = node_lo[r][c][dir_n];
        assign ver_ready_o[dir_n][c]    = node_rdy_lo[r][c][dir_n];
      end else begin : g_n_link
        assign node_li[r][c][dir_n]     = node_lo[r-1][c][dir_s];
        assign node_rdy_li[r][c][dir_n] = node_rdy_lo[r-1][c][dir_s];
      end

      // south side
      if (r == ty_lp - 1) begin : g_s_edge
        assign node_li[r][c][dir_s]     = ver_i[dir_s][c];
        assign node_rdy_li[r][c][dir_s] = ver_ready_i[dir_s][c];
        assign ver_o[dir_s][c]          = node_lo[r][c][dir_s];
        assign ver_ready_o[dir_s][c]    = node_rdy_lo[r][c][dir_s];
      end else begin : g_s_link
        assign node_li[r][c][dir_s]     = node_lo[r+1][c][dir_n];
        assign node_rdy_li[r][c][dir_s] = node_rdy_lo[r+1][c][dir_n];
      end

    end
  end

endmodule

// ==== rtl/mesh_pod_array.sv ====
// ##########################################################################
// top level of the mesh array
//   reset delay chain
//   two pods side by side, stitched east-west
//   north row of IO routers with the processor-side links
//   tie-offs on the west, east and south edges
// ##########################################################################
`include "mesh_macros.svh"

module mesh_pod_array
  import mesh_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  mesh_link_s [`MESH_COLS-1:0]   io_req_i,
  output logic       [`MESH_COLS-1:0]   io_req_ready_o,
  output mesh_link_s [`MESH_COLS-1:0]   io_resp_o,
  input  logic       [`MESH_COLS-1:0]   io_resp_ready_i
);

  localparam int pods_lp = `MESH_PODS_X;
  localparam int cols_lp = `MESH_COLS;
  localparam int tx_lp   = `MESH_TILES_X;
  localparam int depth_lp = `MESH_RESET_DEPTH;

  // reset stays low for depth_lp cycles after rst_n_i rises
  logic [depth_lp-1:0] rst_chain_r;
  logic                core_rst_n;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_chain_r <= '0;
    end else begin
      rst_chain_r <= {rst_chain_r[depth_lp-2:0], 1'b1};
    end
  end

  assign core_rst_n = rst_chain_r[depth_lp-1];

  mesh_link_s [pods_lp-1:0][dir_e:dir_w][`MESH_TILES_Y-1:0] hor_li;
  mesh_link_s [pods_lp-1:0][dir_e:dir_w][`MESH_TILES_Y-1:0] hor_lo;
  logic       [pods_lp-1:0][dir_e:dir_w][`MESH_TILES_Y-1:0] hor_rdy_li;
  logic       [pods_lp-1:0][dir_e:dir_w][`MESH_TILES_Y-1:0] hor_rdy_lo;
  mesh_link_s [pods_lp-1:0][dir_s:dir_n][tx_lp-1:0]         ver_li;
  mesh_link_s [pods_lp-1:0][dir_s:dir_n][tx_lp-1:0]         ver_lo;
  logic       [pods_lp-1:0][dir_s:dir_n][tx_lp-1:0]         ver_rdy_li;
  logic       [pods_lp-1:0][dir_s:dir_n][tx_lp-1:0]         ver_rdy_lo;

  for (genvar p = 0; p < pods_lp; p++) begin : g_pod
    mesh_pod #(
      .pod_x_p(p)
    ) pod (
      .clk_i      (clk_i),
      .rst_n_i    (core_rst_n),
      .hor_i      (hor_li[p]),
      .hor_ready_o(hor_rdy_lo[p]),
      .hor_o      (hor_lo[p]),
      .hor_ready_i(hor_rdy_li[p]),
      .ver_i      (ver_li[p]),
      .ver_ready_o(ver_rdy_lo[p]),
      .ver_o      (ver_lo[p]),
      .ver_ready_i(ver_rdy_li[p])
    );

    // nothing enters from the south edge and everything leaving it is accepted
    assign ver_li[p][dir_s]     = '0;
    assign ver_rdy_li[p][dir_s] = '1;

    if (p == 0) begin : g_w_tie
      assign hor_li[p][dir_w]     = '0;
      assign hor_rdy_li[p][dir_w] = '1;
    end else begin : g_w_link
      assign hor_li[p][dir_w]     = hor_lo[p-1][dir_e];
      assign hor_rdy_li[p][dir_w] = hor_rdy_lo[p-1][dir_e];
    end

    if (p == pods_lp - 1) begin : g_e_tie
      assign hor_li[p][dir_e]     = '0;
      assign hor_rdy_li[p][dir_e] = '1;
    end else begin : g_e_link
      assign hor_li[p][dir_e]     = hor_lo[p+1][dir_w];
      assign hor_rdy_li[p][dir_e] = hor_rdy_lo[p+1][dir_w];
    end
  end

  // north IO row at y 0
  mesh_link_s [cols_lp-1:0][dir_s:dir_p] io_li;
  mesh_link_s [cols_lp-1:0][dir_s:dir_p] io_lo;
  logic       [cols_lp-1:0][dir_s:dir_p] io_rdy_li;
  logic       [cols_lp-1:0][dir_s:dir_p] io_rdy_lo;

  for (genvar i = 0; i < cols_lp; i++) begin : g_io
    mesh_node #(
      .x_cord_p(i),
      .y_cord_p(0)
    ) io_rtr (
      .clk_i       (clk_i),
      .rst_n_i     (core_rst_n),
      .link_i      (io_li[i]),
      .link_ready_o(io_rdy_lo[i]),
      .link_o      (io_lo[i]),
      .link_ready_i(io_rdy_li[i])
    );

    // processor side
    assign io_li[i][dir_p]     = io_req_i[i];
    assign io_req_ready_o[i]   = io_rdy_lo[i][dir_p];
    assign io_resp_o[i]        = io_lo[i][dir_p];
    assign io_rdy_li[i][dir_p] = io_resp_ready_i[i];

    // nothing lies north of the IO row
    assign io_li[i][dir_n]     = '0;
    assign io_rdy_li[i][dir_n] = 1'b1;

    // south into the top tile row of the pod below
    assign ver_li[i/tx_lp][dir_n][i%tx_lp]     = io_lo[i][dir_s];
    assign ver_rdy_li[i/tx_lp][dir_n][i%tx_lp] = io_rdy_lo[i][dir_s];
    assign io_li[i][dir_s]                     = ver_lo[i/tx_lp][dir_n][i%tx_lp];
    assign io_rdy_li[i][dir_s]                 = ver_rdy_lo[i/tx_lp][dir_n][i%tx_lp];

    if (i == 0) begin : g_w_tie
      assign io_li[i][dir_w]     = '0;
      assign io_rdy_li[i][dir_w] = 1'b1;
    end else begin : g_w_link
      assign io_li[i][dir_w]     = io_lo[i-1][dir_e];
      assign io_rdy_li[i][dir_w] = io_rdy_lo[i-1][dir_e];
    end

    if (i == cols_lp - 1) begin : g_e_tie
      assign io_li[i][dir_e]     = '0;
      assign io_rdy_li[i][dir_e] = 1'b1;
    end else begin : g_e_link
      assign io_li[i][dir_e]     = io_lo[i+1][dir_w];
      assign io_rdy_li[i][dir_e] = io_rdy_lo[i+1][dir_w];
    end
  end

endmodule

// ==== rtl/mesh_tile_mem.sv ====
// ##########################################################################
// tile endpoint with a small remote-access memory
// stores writes, answers reads, one response per request
// ##########################################################################
`include "mesh_macros.svh"

module mesh_tile_mem
  import mesh_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  mesh_link_s req_i,
  output logic       req_ready_o,
  output mesh_link_s resp_o,
  input  logic       resp_ready_i
);

  localparam int words_lp = 1 << `MESH_ADDR_W;

  logic [`MESH_DATA_W-1:0] mem_r [words_lp];

  logic      resp_v_r;
  mesh_pkt_s resp_pkt_r;
  logic      accept;

  // a new request fits when the response register is empty or draining
  assign req_ready_o = ~resp_v_r | resp_ready_i;
  assign accept      = req_i.v & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_v_r <= 1'b0;
    end else if (accept) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.pkt.op == op_write) begin
        mem_r[req_i.pkt.addr] <= req_i.pkt.data;
        resp_pkt_r.data       <= req_i.pkt.data;
      end else begin
        resp_pkt_r.data <= mem_r[req_i.pkt.addr];
      end
      // reply travels back to whoever asked
      resp_pkt_r.op    <= op_resp;
      resp_pkt_r.src_x <= req_i.pkt.dst_x;
      resp_pkt_r.src_y <= req_i.pkt.dst_y;
      resp_pkt_r.dst_x <= req_i.pkt.src_x;
      resp_pkt_r.dst_y <= req_i.pkt.src_y;
      resp_pkt_r.addr  <= req_i.pkt.addr;
    end
  end

  assign resp_o.v   = resp_v_r;
  assign resp_o.pkt = resp_pkt_r;

endmodule

// ==== verif/tb_mesh_pod_array.sv ====
// ##########################################################################
// testbench of the mesh array
//   clock, reset sequence and per-column request drivers
//   reference memory model with the expected response function
//   response monitor comparing against per column and tile queues
//   reset, basic, random, back-pressure and mid-traffic reset tests
// ##########################################################################
`include "mesh_macros.svh"

module tb_mesh_pod_array
  import mesh_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cols_lp  = `MESH_COLS;
  localparam int tiles_lp = 8;
  localparam int words_lp = 1 << `MESH_ADDR_W;
  localparam int tmo_lp   = 2000;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  mesh_link_s [cols_lp-1:0]   io_req_i;
  logic       [cols_lp-1:0]   io_req_ready_o;
  mesh_link_s [cols_lp-1:0]   io_resp_o;
  logic       [cols_lp-1:0]   io_resp_ready_i;

  logic [`MESH_DATA_W-1:0] model_mem [tiles_lp*words_lp];
  logic                    written   [tiles_lp*words_lp];
  // indexed by column times tiles_lp plus tile
  mesh_pkt_s               exp_q     [cols_lp*tiles_lp][$];

  int checks;
  int errors;
  int req_cnt;
  int resp_cnt;
  int dropped;

  mesh_pod_array mesh_pod_array_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .io_req_i       (io_req_i),
    .io_req_ready_o (io_req_ready_o),
    .io_resp_o      (io_resp_o),
    .io_resp_ready_i(io_resp_ready_i)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("Timeout while waiting for %s", what);
    $display("Regression failed");
    $finish;
  endtask

  // expected response from the model memory state at request time
  function automatic mesh_pkt_s expected_resp(mesh_pkt_s req);
    mesh_pkt_s rsp;
    int        t;
    t         = (int'(req.dst_y) - 1) * cols_lp + int'(req.dst_x);
    rsp.op    = op_resp;
    rsp.src_x = req.dst_x;
    rsp.src_y = req.dst_y;
    rsp.dst_x = req.src_x;
    rsp.dst_y = req.src_y;
    rsp.addr  = req.addr;
    rsp.data  = (req.op == op_write) ? req.data : model_mem[t*words_lp + int'(req.addr)];
    return rsp;
  endfunction

  task automatic record_req(int c, mesh_pkt_s req);
    int t;
    t = (int'(req.dst_y) - 1) * cols_lp + int'(req.dst_x);
    exp_q[c*tiles_lp + t].push_back(expected_resp(req));
    if (req.op == op_write) begin
      model_mem[t*words_lp + int'(req.addr)] = req.data;
      written[t*words_lp + int'(req.addr)]   = 1'b1;
    end
    req_cnt++;
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_req(int c, mesh_pkt_s req);
    int n;
    n = 0;
    io_req_i[c].pkt = req;
    io_req_i[c].v   = 1'b1;
    while (!io_req_ready_o[c]) begin
      @(negedge clk_i);
      n++;
      if (n > tmo_lp) timeout_fail($sformatf("io_req_ready_o[%0d]", c));
    end
    record_req(c, req);
    @(negedge clk_i);
    io_req_i[c].v = 1'b0;
  endtask

  function automatic mesh_pkt_s make_req(int c, int t, bit rd_only);
    mesh_pkt_s req;
    int        idx;
    req.src_x = (`MESH_X_W)'(c);
    req.src_y = '0;
    req.dst_x = (`MESH_X_W)'(t % cols_lp);
    req.dst_y = (`MESH_Y_W)'(t / cols_lp + 1);
    req.addr  = {2'(c), 2'($urandom % 4)};
    req.data  = $urandom;
    // a read goes to a location this column has already written
    if (rd_only) begin
      for (int a = 0; a < 4; a++) begin
        if (written[t*words_lp + c*4 + a]) req.addr = {2'(c), 2'(a)};
      end
    end
    idx       = t*words_lp + int'(req.addr);
    req.op    = (written[idx] && (rd_only || $urandom % 2)) ? op_read : op_write;
    return req;
  endfunction

  task automatic random_burst(int c, int count);
    for (int k = 0; k < count; k++) begin
      send_req(c, make_req(c, $urandom % tiles_lp, 1'b0));
    end
  endtask

  function automatic bit all_empty();
    for (int q = 0; q < cols_lp*tiles_lp; q++) begin
      if (exp_q[q].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    while (!all_empty()) begin
      @(negedge clk_i);
      n++;
      if (n > tmo_lp) timeout_fail("outstanding responses");
    end
  endtask

  // valids and readies low through reset and the delay chain
  task automatic reset_seq();
    int n;
    rst_n_i = 1'b0;
    for (int i = 0; i < 5 + `MESH_RESET_DEPTH; i++) begin
      @(negedge clk_i);
      if (i == 4) rst_n_i = 1'b1;
      if (i >= 2) begin
        for (int c = 0; c < cols_lp; c++) begin
          check_val($sformatf("io_resp_o[%0d].v", c), 64'(io_resp_o[c].v), 64'd0);
          check_val($sformatf("io_req_ready_o[%0d]", c), 64'(io_req_ready_o[c]), 64'd0);
        end
      end
    end
    n = 0;
    while (io_req_ready_o != '1) begin
      @(negedge clk_i);
      n++;
      if (n > tmo_lp) timeout_fail("io_req_ready_o after reset");
    end
  endtask

  // a transfer is seen at the rising edge with pre-edge values
  always @(posedge clk_i) begin
    int        t;
    mesh_pkt_s exp;
    for (int c = 0; c < cols_lp; c++) begin
      if (io_resp_o[c].v && io_resp_ready_i[c]) begin
        resp_cnt++;
        t = (int'(io_resp_o[c].pkt.src_y) - 1) * cols_lp + int'(io_resp_o[c].pkt.src_x);
        if (t < 0 || t >= tiles_lp || exp_q[c*tiles_lp + t].size() == 0) begin
          errors++;
          $display("Unexpected response on column %0d from an unknown tile or with none due", c);
        end else begin
          exp = exp_q[c*tiles_lp + t].pop_front();
          check_val($sformatf("io_resp_o[%0d].pkt", c), 64'(io_resp_o[c].pkt), 64'(exp));
        end
      end
    end
  end

  task automatic report(string name, int err_before);
    $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  initial begin
    int e;
    int hold;
    int low_run;
    void'($urandom(32'h1155));
    checks = 0;
    errors = 0;
    req_cnt = 0;
    resp_cnt = 0;
    dropped = 0;
    rst_n_i = 1'b0;
    io_req_i = '0;
    io_resp_ready_i = '1;
    for (int i = 0; i < tiles_lp*words_lp; i++) written[i] = 1'b0;

    e = errors;
    reset_seq();
    repeat (20) @(negedge clk_i);
    check_val("resp_cnt", 64'(resp_cnt), 64'd0);
    report("test 1 reset", e);

    e = errors;
    send_req(1, make_req(1, 7, 1'b0));
    send_req(1, make_req(1, 7, 1'b1));
    wait_drain();
    report("test 2 write then read", e);

    e = errors;
    fork
      random_burst(0, 20);
      random_burst(1, 20);
      random_burst(2, 20);
      random_burst(3, 20);
    join
    wait_drain();
    check_val("req_cnt", 64'(req_cnt), 64'(resp_cnt));
    report("test 3 random traffic", e);

    // columns 0 and 2 stall until the request side backs up
    e = errors;
    io_resp_ready_i = 4'b1010;
    fork
      begin
        for (int k = 0; k < 16; k++) send_req(0, make_req(0, 0, 1'b0));
      end
      begin
        random_burst(2, 16);
      end
      begin
        low_run = 0;
        hold = 0;
        while (low_run < 10) begin
          @(negedge clk_i);
          low_run = io_req_ready_o[0] ? 0 : low_run + 1;
          hold++;
          if (hold > tmo_lp) timeout_fail("io_req_ready_o[0] to drop");
        end
        repeat (20 + $urandom % 40) @(negedge clk_i);
        io_resp_ready_i = '1;
      end
    join
    wait_drain();
    check_val("req_cnt", 64'(req_cnt), 64'(resp_cnt));
    report("test 4 back-pressure", e);

    // reads only are held in flight so the model memory stays exact
    e = errors;
    for (int c = 0; c < cols_lp; c++) begin
      send_req(c, make_req(c, c, 1'b0));
    end
    wait_drain();
    io_resp_ready_i = '0;
    for (int c = 0; c < cols_lp; c++) begin
      send_req(c, make_req(c, c, 1'b1));
    end
    repeat (4) @(negedge clk_i);
    reset_seq();
    for (int q = 0; q < cols_lp*tiles_lp; q++) begin
      dropped += exp_q[q].size();
      exp_q[q].delete();
    end
    io_resp_ready_i = '1;
    fork
      random_burst(0, 8);
      random_burst(3, 8);
    join
    wait_drain();
    check_val("req_cnt", 64'(req_cnt), 64'(resp_cnt + dropped));
    report("test 5 reset mid-traffic", e);

    $display("checks %0d, errors %0d, requests %0d, responses %0d, dropped %0d",
             checks, errors, req_cnt, resp_cnt, dropped);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
